//--- dv/rv_exec_assertions.sv
`timescale 1ns/100ps

module rv_exec_assertions (
    input logic                          clk,
    input logic                          reset,
    input logic                          inst_valid,
    input logic                          result_valid,
    input logic                          branch_taken,
    input logic [rv_pkg::word_width-1:0] pc
);

    logic started;
    int   fail_count = 0;

    // set once the first instruction has been sampled
    always_ff @(posedge clk)
    begin
        if (reset)
            started <= 1'b0;
        else if (inst_valid)
            started <= 1'b1;
    end

    quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
        !started |-> (!result_valid && !branch_taken && (pc == '0)))
    else
    begin
        $error("core reported activity before the first instruction");
        fail_count++;
    end

    // a write and a taken branch never come from the same instruction
    never_both: assert property (@(posedge clk) disable iff (reset)
        !(result_valid && branch_taken))
    else
    begin
        $error("result_valid and branch_taken high together");
        fail_count++;
    end

    fixed_latency: assert property (@(posedge clk) disable iff (reset)
        (result_valid || branch_taken) |-> $past(inst_valid, 2))
    else
    begin
        $error("output pulse without an instruction two edges earlier");
        fail_count++;
    end

endmodule

bind rv_exec_core rv_exec_assertions u_assertions (
    .clk          (clk),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .result_valid (result_valid),
    .branch_taken (branch_taken),
    .pc           (pc)
);

//--- dv/rv_exec_tb.sv
`timescale 1ns/100ps

module rv_exec_tb;

    localparam int clk_period     = 100;
    localparam int seed           = 99848;
    localparam int table_len      = 38;
    localparam int rand_count     = 40;
    localparam int reset_cycles   = 4;
    localparam int timeout_cycles = (table_len + rand_count) * 3 + reset_cycles;

    typedef struct packed {
        logic        rv;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        bt;
        logic [31:0] pc;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst;
    logic        result_valid;
    logic [4:0]  result_rd;
    logic [31:0] result_data;
    logic        branch_taken;
    logic [31:0] pc;

    // stimulus table with a test id per entry
    logic [31:0] tbl_inst [table_len];
    expect_t     tbl_exp  [table_len];
    int          tbl_test [table_len];
    int          tbl_fill;

    // expectations in flight for two edges
    expect_t     exp_d1;
    expect_t     exp_d2;
    logic [31:0] exp_pc;
    logic [31:0] model_regs [32];
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          assert_fails;

    rv_exec_core dut (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data),
        .branch_taken (branch_taken),
        .pc           (pc)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // instruction encoders
    function automatic logic [31:0] enc_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                          logic [11:0] imm);
        return {imm, rs1, f3, rd, rv_pkg::op_alu_imm};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rv_pkg::op_alu_reg};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch};
    endfunction

    function automatic expect_t idle_expect();
        expect_t e;
        e.rv   = 1'b0;
        e.rd   = 5'd0;
        e.data = 32'd0;
        e.bt   = 1'b0;
        e.pc   = exp_pc;
        return e;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want)
        begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic check_outputs(expect_t e);
        check_value("result_valid", 32'(result_valid), 32'(e.rv));
        check_value("branch_taken", 32'(branch_taken), 32'(e.bt));
        check_value("pc", pc, e.pc);
        if (e.rv)
        begin
            check_value("result_rd", 32'(result_rd), 32'(e.rd));
            check_value("result_data", result_data, e.data);
        end
    endtask

    // check the instruction issued two edges back and drive the next one
    task automatic step(logic v, logic [31:0] word, expect_t e);
        @(posedge clk);
        #10;
        check_outputs(exp_d2);
        exp_d2     = exp_d1;
        exp_d1     = e;
        inst_valid = v;
        inst       = word;
    endtask

    task automatic finish_test(string name, int err_start);
        step(1'b0, rv_pkg::nop_inst, idle_expect());
        step(1'b0, rv_pkg::nop_inst, idle_expect());
        tests_run++;
        if (errors > err_start)
            tests_failed++;
        $display("test %-8s %s, %0d errors", name, (errors > err_start) ? "FAIL" : "ok",
                 errors - err_start);
    endtask

    task automatic add_entry(int test, logic [31:0] word, logic rv, logic [4:0] rd,
                             logic [31:0] data, logic bt, logic [31:0] next_pc);
        tbl_test[tbl_fill]      = test;
        tbl_inst[tbl_fill]      = word;
        tbl_exp[tbl_fill].rv    = rv;
        tbl_exp[tbl_fill].rd    = rd;
        tbl_exp[tbl_fill].data  = data;
        tbl_exp[tbl_fill].bt    = bt;
        tbl_exp[tbl_fill].pc    = next_pc;
        tbl_fill++;
    endtask

    task automatic fill_table();
        // i-type chain on dependent registers
        add_entry(0, enc_i(3'd0, 5'd1, 5'd0, 12'd100), 1'b1, 5'd1, 32'd100, 1'b0, 32'd4);
        add_entry(0, enc_i(3'd0, 5'd2, 5'd0, 12'hFF9), 1'b1, 5'd2, 32'hFFFFFFF9, 1'b0, 32'd8);
        add_entry(0, enc_i(3'd0, 5'd3, 5'd0, 12'h800), 1'b1, 5'd3, 32'hFFFFF800, 1'b0, 32'd12);
        add_entry(0, enc_i(3'd2, 5'd4, 5'd2, 12'hFFB), 1'b1, 5'd4, 32'd1, 1'b0, 32'd16);
        add_entry(0, enc_i(3'd3, 5'd5, 5'd2, 12'd5), 1'b1, 5'd5, 32'd0, 1'b0, 32'd20);
        add_entry(0, enc_i(3'd4, 5'd6, 5'd1, 12'h0FF), 1'b1, 5'd6, 32'h9B, 1'b0, 32'd24);
        add_entry(0, enc_i(3'd6, 5'd7, 5'd6, 12'hF00), 1'b1, 5'd7, 32'hFFFFFF9B, 1'b0, 32'd28);
        add_entry(0, enc_i(3'd7, 5'd8, 5'd7, 12'h7F0), 1'b1, 5'd8, 32'h790, 1'b0, 32'd32);
        add_entry(0, enc_i(3'd1, 5'd9, 5'd8, 12'd20), 1'b1, 5'd9, 32'h79000000, 1'b0, 32'd36);
        add_entry(0, enc_i(3'd5, 5'd10, 5'd7, 12'd8), 1'b1, 5'd10, 32'h00FFFFFF, 1'b0, 32'd40);
        add_entry(0, enc_i(3'd5, 5'd11, 5'd7, 12'h404), 1'b1, 5'd11, 32'hFFFFFFF9, 1'b0, 32'd44);
        add_entry(0, enc_i(3'd0, 5'd0, 5'd1, 12'd5), 1'b0, 5'd0, 32'd0, 1'b0, 32'd48);
        // r-type ops use x1 = 100 x2 = -7 x3 = -2048 x4 = 1
        add_entry(1, enc_r(7'h00, 3'd0, 5'd12, 5'd1, 5'd2), 1'b1, 5'd12, 32'h5D, 1'b0, 32'd52);
        add_entry(1, enc_r(7'h20, 3'd0, 5'd13, 5'd2, 5'd1), 1'b1, 5'd13, 32'hFFFFFF95, 1'b0,
                  32'd56);
        add_entry(1, enc_r(7'h00, 3'd1, 5'd14, 5'd1, 5'd2), 1'b1, 5'd14, 32'hC8000000, 1'b0,
                  32'd60);
        add_entry(1, enc_r(7'h00, 3'd2, 5'd15, 5'd2, 5'd1), 1'b1, 5'd15, 32'd1, 1'b0, 32'd64);
        add_entry(1, enc_r(7'h00, 3'd3, 5'd16, 5'd2, 5'd1), 1'b1, 5'd16, 32'd0, 1'b0, 32'd68);
        add_entry(1, enc_r(7'h00, 3'd4, 5'd17, 5'd1, 5'd2), 1'b1, 5'd17, 32'hFFFFFF9D, 1'b0,
                  32'd72);
        add_entry(1, enc_r(7'h00, 3'd5, 5'd18, 5'd3, 5'd4), 1'b1, 5'd18, 32'h7FFFFC00, 1'b0,
                  32'd76);
        add_entry(1, enc_r(7'h20, 3'd5, 5'd19, 5'd3, 5'd4), 1'b1, 5'd19, 32'hFFFFFC00, 1'b0,
                  32'd80);
        add_entry(1, enc_r(7'h00, 3'd6, 5'd20, 5'd1, 5'd9), 1'b1, 5'd20, 32'h79000064, 1'b0,
                  32'd84);
        add_entry(1, enc_r(7'h00, 3'd7, 5'd21, 5'd2, 5'd1), 1'b1, 5'd21, 32'h60, 1'b0, 32'd88);
        add_entry(1, enc_r(7'h00, 3'd3, 5'd22, 5'd1, 5'd2), 1'b1, 5'd22, 32'd1, 1'b0, 32'd92);
        add_entry(1, enc_r(7'h00, 3'd2, 5'd23, 5'd1, 5'd2), 1'b1, 5'd23, 32'd0, 1'b0, 32'd96);
        // each branch condition taken and then not taken
        add_entry(2, enc_b(3'd0, 5'd4, 5'd4, 13'd16), 1'b0, 5'd0, 32'd0, 1'b1, 32'd112);
        add_entry(2, enc_b(3'd0, 5'd1, 5'd2, 13'd16), 1'b0, 5'd0, 32'd0, 1'b0, 32'd116);
        add_entry(2, enc_b(3'd1, 5'd1, 5'd2, 13'h1FF8), 1'b0, 5'd0, 32'd0, 1'b1, 32'd108);
        add_entry(2, enc_b(3'd1, 5'd4, 5'd4, 13'd8), 1'b0, 5'd0, 32'd0, 1'b0, 32'd112);
        add_entry(2, enc_b(3'd4, 5'd2, 5'd1, 13'd32), 1'b0, 5'd0, 32'd0, 1'b1, 32'd144);
        add_entry(2, enc_b(3'd4, 5'd1, 5'd2, 13'd32), 1'b0, 5'd0, 32'd0, 1'b0, 32'd148);
        add_entry(2, enc_b(3'd5, 5'd1, 5'd2, 13'd12), 1'b0, 5'd0, 32'd0, 1'b1, 32'd160);
        add_entry(2, enc_b(3'd5, 5'd2, 5'd1, 13'd12), 1'b0, 5'd0, 32'd0, 1'b0, 32'd164);
        add_entry(2, enc_b(3'd6, 5'd1, 5'd2, 13'd20), 1'b0, 5'd0, 32'd0, 1'b1, 32'd184);
        add_entry(2, enc_b(3'd6, 5'd2, 5'd1, 13'd20), 1'b0, 5'd0, 32'd0, 1'b0, 32'd188);
        add_entry(2, enc_b(3'd7, 5'd2, 5'd1, 13'h1FD8), 1'b0, 5'd0, 32'd0, 1'b1, 32'd148);
        add_entry(2, enc_b(3'd7, 5'd4, 5'd1, 13'd8), 1'b0, 5'd0, 32'd0, 1'b0, 32'd152);
        // custom-0 opcode aimed at x1 and a read of x1 afterwards
        add_entry(3, {12'h123, 5'd1, 3'd0, 5'd1, 7'b0001011}, 1'b0, 5'd0, 32'd0, 1'b0, 32'd156);
        add_entry(3, enc_i(3'd0, 5'd24, 5'd1, 12'd0), 1'b1, 5'd24, 32'd100, 1'b0, 32'd160);
    endtask

    task automatic run_table(int id, string name);
        int err_start;
        err_start = errors;
        for (int i = 0; i < tbl_fill; i++)
        begin
            if (tbl_test[i] == id)
            begin
                exp_pc = tbl_exp[i].pc;
                if (tbl_exp[i].rv)
                    model_regs[tbl_exp[i].rd] = tbl_exp[i].data;
                step(1'b1, tbl_inst[i], tbl_exp[i]);
            end
        end
        finish_test(name, err_start);
    endtask

    task automatic run_random();
        int          err_start;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic        use_reg;
        logic [31:0] word;
        logic [31:0] value;
        expect_t     e;
        err_start = errors;
        for (int k = 0; k < rand_count; k++)
        begin
            if ($urandom_range(3) == 0)
                step(1'b0, rv_pkg::nop_inst, idle_expect());
            rd      = 5'($urandom_range(31));
            rs1     = 5'($urandom_range(31));
            rs2     = 5'($urandom_range(31));
            imm     = 12'($urandom);
            use_reg = 1'($urandom_range(1));
            if (use_reg)
            begin
                word  = enc_r(7'h00, 3'd0, rd, rs1, rs2);
                value = model_regs[rs1] + model_regs[rs2];
            end
            else
            begin
                word  = enc_i(3'd0, rd, rs1, imm);
                value = model_regs[rs1] + {{20{imm[11]}}, imm};
            end
            exp_pc = exp_pc + 32'd4;
            if (rd != 5'd0)
                model_regs[rd] = value;
            e.rv   = (rd != 5'd0);
            e.rd   = rd;
            e.data = value;
            e.bt   = 1'b0;
            e.pc   = exp_pc;
            step(1'b1, word, e);
        end
        finish_test("random", err_start);
    endtask

    initial
    begin
        #(timeout_cycles * clk_period);
        $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        void'($urandom(seed));
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst         = rv_pkg::nop_inst;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        tbl_fill     = 0;
        exp_pc       = 32'd0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = 32'd0;
        exp_d1 = idle_expect();
        exp_d2 = idle_expect();
        fill_table();
        repeat (reset_cycles) @(posedge clk);
        #10;
        reset = 1'b0;
        check_outputs(idle_expect());
        finish_test("reset", 0);
        run_table(0, "i-type");
        run_table(1, "r-type");
        run_table(2, "branch");
        run_table(3, "unknown");
        run_random();
        // bound assertion failures count as errors too
        assert_fails = dut.u_assertions.fail_count;
        errors       = errors + assert_fails;
        $display("%0d tests, %0d failed, %0d assertion failures, %0d errors", tests_run,
                 tests_failed, assert_fails, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- rtl/alu_branch_unit.sv
`timescale 1ns/100ps

module alu_branch_unit (
    rv_exec_if.execute_side                   exe,
    output logic [rv_pkg::reg_addr_width-1:0] rd_addr_a,
    output logic [rv_pkg::reg_addr_width-1:0] rd_addr_b,
    input  logic [rv_pkg::word_width-1:0]     rd_data_a,
    input  logic [rv_pkg::word_width-1:0]     rd_data_b,
    input  logic [rv_pkg::word_width-1:0]     pc,
    output logic [rv_pkg::word_width-1:0]     alu_result,
    output logic                              take_branch,
    output logic [rv_pkg::word_width-1:0]     next_pc
);

    logic [rv_pkg::word_width-1:0] op_a;
    logic [rv_pkg::word_width-1:0] op_b;
    logic [4:0]                    shamt;
    logic                          lt_signed;
    logic                          lt_unsigned;
    logic                          equal;
    logic                          cond_met;

    assign rd_addr_a = exe.rs1;
    assign rd_addr_b = exe.rs2;

    // operand b is the immediate for the i-type group
    assign op_a  = rd_data_a;
    assign op_b  = exe.use_imm ? exe.imm : rd_data_b;
    assign shamt = op_b[4:0];

    // shared comparators for slt/sltu and the branches
    assign lt_signed   = ($signed(op_a) < $signed(op_b));
    assign lt_unsigned = (op_a < op_b);
    assign equal       = (op_a == op_b);

    always_comb
    begin
        case (exe.alu_fun)
            rv_pkg::alu_add:
                alu_result = op_a + op_b;
            rv_pkg::alu_sub:
                alu_result = op_a - op_b;
            rv_pkg::alu_sll:
                alu_result = op_a << shamt;
            rv_pkg::alu_srl:
                alu_result = op_a >> shamt;
            rv_pkg::alu_sra:
                alu_result = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::alu_and:
                alu_result = op_a & op_b;
            rv_pkg::alu_or:
                alu_result = op_a | op_b;
            rv_pkg::alu_xor:
                alu_result = op_a ^ op_b;
            rv_pkg::alu_slt:
                alu_result = {{(rv_pkg::word_width-1){1'b0}}, lt_signed};
            rv_pkg::alu_sltu:
                alu_result = {{(rv_pkg::word_width-1){1'b0}}, lt_unsigned};
            default:
                alu_result = '0;
        endcase
    end

    // branch condition by funct3, codes 2 and 3 never branch
    always_comb
    begin
        case (exe.funct3)
            3'd0:    cond_met = equal;
            3'd1:    cond_met = !equal;
            3'd4:    cond_met = lt_signed;
            3'd5:    cond_met = !lt_signed;
            3'd6:    cond_met = lt_unsigned;
            3'd7:    cond_met = !lt_unsigned;
            default: cond_met = 1'b0;
        endcase
    end

    assign take_branch = exe.valid && exe.is_branch && cond_met;
    assign next_pc     = take_branch ? (pc + exe.imm) : (pc + 32'd4);

endmodule

//--- rtl/inst_decode.sv
`timescale 1ns/100ps

module inst_decode (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          inst_valid,
    input  logic [rv_pkg::word_width-1:0] inst,
    rv_exec_if.decode_side                dec
);

    rv_pkg::inst_t                 inst_q;
    logic                          valid_q;
    logic [6:0]                    opcode;
    logic                          is_alu_imm;
    logic                          is_alu_reg;
    logic [rv_pkg::word_width-1:0] i_imm;
    logic [rv_pkg::word_width-1:0] b_imm;

    // instruction register, idles on a nop
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            inst_q  <= rv_pkg::nop_inst;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= inst_valid;
            if (inst_valid)
                inst_q <= inst;
        end
    end

    assign opcode     = inst_q.i_view.opcode;
    assign is_alu_imm = (opcode == rv_pkg::op_alu_imm);
    assign is_alu_reg = (opcode == rv_pkg::op_alu_reg);

    // sign extended immediates
    assign i_imm = {{20{inst_q.i_view.imm[11]}}, inst_q.i_view.imm};
    assign b_imm = {{19{inst_q.b_view.imm12}}, inst_q.b_view.imm12, inst_q.b_view.imm11,
                    inst_q.b_view.imm10_5, inst_q.b_view.imm4_1, 1'b0};

    assign dec.rs1       = inst_q.r_view.rs1;
    assign dec.rs2       = inst_q.r_view.rs2;
    assign dec.rd        = inst_q.r_view.rd;
    assign dec.funct3    = inst_q.r_view.funct3;
    assign dec.imm       = (opcode == rv_pkg::op_branch) ? b_imm : i_imm;
    assign dec.use_imm   = is_alu_imm;
    assign dec.is_branch = (opcode == rv_pkg::op_branch);
    assign dec.valid     = valid_q;

    // writes to x0 are dropped right here
    assign dec.is_alu = (is_alu_imm || is_alu_reg) && (inst_q.r_view.rd != '0);

    // funct3 to alu function
    always_comb
    begin
        case (inst_q.r_view.funct3)
            3'd0:
            begin
                // sub exists only in the register form
                if (is_alu_reg && inst_q.r_view.funct7[5])
                    dec.alu_fun = rv_pkg::alu_sub;
                else
                    dec.alu_fun = rv_pkg::alu_add;
            end
            3'd1:
                dec.alu_fun = rv_pkg::alu_sll;
            3'd2:
                dec.alu_fun = rv_pkg::alu_slt;
            3'd3:
                dec.alu_fun = rv_pkg::alu_sltu;
            3'd4:
                dec.alu_fun = rv_pkg::alu_xor;
            3'd5:
            begin
                // bit 30 selects arithmetic shift in both forms
                if (inst_q.i_view.imm[10])
                    dec.alu_fun = rv_pkg::alu_sra;
                else
                    dec.alu_fun = rv_pkg::alu_srl;
            end
            3'd6:
                dec.alu_fun = rv_pkg::alu_or;
            default:
                dec.alu_fun = rv_pkg::alu_and;
        endcase
    end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [rv_pkg::reg_addr_width-1:0] rd_addr_a,
    input  logic [rv_pkg::reg_addr_width-1:0] rd_addr_b,
    output logic [rv_pkg::word_width-1:0]     rd_data_a,
    output logic [rv_pkg::word_width-1:0]     rd_data_b,
    input  logic                              wr_en,
    input  logic [rv_pkg::reg_addr_width-1:0] wr_addr,
    input  logic [rv_pkg::word_width-1:0]     wr_data
);

    logic [rv_pkg::word_width-1:0] regs [rv_pkg::num_regs];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < rv_pkg::num_regs; i++)
                regs[i] <= '0;
        end
        else if (wr_en && (wr_addr != '0))
        begin
            // x0 never changes, so it always reads zero
            regs[wr_addr] <= wr_data;
        end
    end

    // asynchronous read ports
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

//--- rtl/rv_exec_core.sv
`timescale 1ns/100ps

module rv_exec_core (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              inst_valid,
    input  logic [rv_pkg::word_width-1:0]     inst,
    output logic                              result_valid,
    output logic [rv_pkg::reg_addr_width-1:0] result_rd,
    output logic [rv_pkg::word_width-1:0]     result_data,
    output logic                              branch_taken,
    output logic [rv_pkg::word_width-1:0]     pc
);

    logic [rv_pkg::reg_addr_width-1:0] rd_addr_a;
    logic [rv_pkg::reg_addr_width-1:0] rd_addr_b;
    logic [rv_pkg::word_width-1:0]     rd_data_a;
    logic [rv_pkg::word_width-1:0]     rd_data_b;
    logic                              wr_en;
    logic [rv_pkg::reg_addr_width-1:0] wr_addr;
    logic [rv_pkg::word_width-1:0]     wr_data;
    logic [rv_pkg::word_width-1:0]     alu_result;
    logic                              take_branch;
    logic [rv_pkg::word_width-1:0]     next_pc;

    rv_exec_if exec_bus ();

    inst_decode u_decode (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec        (exec_bus.decode_side)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    // pc feeds back from writeback into the branch target
    alu_branch_unit u_alu_branch (
        .exe         (exec_bus.execute_side),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .pc          (pc),
        .alu_result  (alu_result),
        .take_branch (take_branch),
        .next_pc     (next_pc)
    );

    writeback u_writeback (
        .clk          (clk),
        .reset        (reset),
        .exe          (exec_bus.execute_side),
        .alu_result   (alu_result),
        .take_branch  (take_branch),
        .next_pc      (next_pc),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data),
        .branch_taken (branch_taken),
        .pc           (pc)
    );

endmodule

//--- rtl/rv_exec_if.sv
`timescale 1ns/100ps

// decoded instruction handed from decode to execute
interface rv_exec_if;

    logic [rv_pkg::reg_addr_width-1:0] rs1;
    logic [rv_pkg::reg_addr_width-1:0] rs2;
    logic [rv_pkg::reg_addr_width-1:0] rd;
    logic [rv_pkg::word_width-1:0]     imm;
    logic [2:0]                        funct3;
    rv_pkg::alu_fun_t                  alu_fun;
    logic                              use_imm;
    logic                              is_alu;
    logic                              is_branch;
    // high for the one cycle a decoded instruction is held
    logic                              valid;

    modport decode_side (
        output rs1, rs2, rd, imm, funct3, alu_fun,
        output use_imm, is_alu, is_branch, valid
    );

    modport execute_side (
        input rs1, rs2, rd, imm, funct3, alu_fun,
        input use_imm, is_alu, is_branch, valid
    );

endinterface

//--- rtl/rv_pkg.sv
package rv_pkg;

    // data path and register file sizes
    localparam int word_width     = 32;
    localparam int num_regs       = 32;
    localparam int reg_addr_width = 5;

    // major opcodes of the three supported groups
    localparam logic [6:0] op_alu_imm = 7'b0010011;
    localparam logic [6:0] op_alu_reg = 7'b0110011;
    localparam logic [6:0] op_branch  = 7'b1100011;

    // addi x0, x0, 0
    localparam logic [word_width-1:0] nop_inst = 32'h0000_0013;

    typedef logic [3:0] alu_fun_t;

    // alu function codes
    localparam alu_fun_t alu_add  = 4'd0;
    localparam alu_fun_t alu_sub  = 4'd1;
    localparam alu_fun_t alu_sll  = 4'd2;
    localparam alu_fun_t alu_srl  = 4'd3;
    localparam alu_fun_t alu_sra  = 4'd4;
    localparam alu_fun_t alu_and  = 4'd5;
    localparam alu_fun_t alu_or   = 4'd6;
    localparam alu_fun_t alu_xor  = 4'd7;
    localparam alu_fun_t alu_slt  = 4'd8;
    localparam alu_fun_t alu_sltu = 4'd9;

    // immediate format, also used for the alu immediate ops
    typedef struct packed {
        logic [11:0]               imm;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0]                funct3;
        logic [reg_addr_width-1:0] rd;
        logic [6:0]                opcode;
    } i_fields_t;

    // register to register format
    typedef struct packed {
        logic [6:0]                funct7;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0]                funct3;
        logic [reg_addr_width-1:0] rd;
        logic [6:0]                opcode;
    } r_fields_t;

    // branch format, offset bits are scattered over the word
    typedef struct packed {
        logic                      imm12;
        logic [5:0]                imm10_5;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0]                funct3;
        logic [3:0]                imm4_1;
        logic                      imm11;
        logic [6:0]                opcode;
    } b_fields_t;

    // one instruction word, three ways to read it
    typedef union packed {
        i_fields_t i_view;
        r_fields_t r_view;
        b_fields_t b_view;
    } inst_t;

endpackage

//--- rtl/writeback.sv
`timescale 1ns/100ps

module writeback (
    input  logic                              clk,
    input  logic                              reset,
    rv_exec_if.execute_side                   exe,
    input  logic [rv_pkg::word_width-1:0]     alu_result,
    input  logic                              take_branch,
    input  logic [rv_pkg::word_width-1:0]     next_pc,
    output logic                              wr_en,
    output logic [rv_pkg::reg_addr_width-1:0] wr_addr,
    output logic [rv_pkg::word_width-1:0]     wr_data,
    output logic                              result_valid,
    output logic [rv_pkg::reg_addr_width-1:0] result_rd,
    output logic [rv_pkg::word_width-1:0]     result_data,
    output logic                              branch_taken,
    output logic [rv_pkg::word_width-1:0]     pc
);

    // register file write lands on the same edge as the result register
    assign wr_en   = exe.valid && exe.is_alu;
    assign wr_addr = exe.rd;
    assign wr_data = alu_result;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            result_valid <= 1'b0;
            branch_taken <= 1'b0;
            pc           <= '0;
        end
        else
        begin
            result_valid <= wr_en;
            branch_taken <= take_branch;
            // every held instruction moves the pc, nops included
            if (exe.valid)
                pc <= next_pc;
        end
    end

    always_ff @(posedge clk)
    begin
        if (exe.valid)
        begin
            result_rd   <= exe.rd;
            result_data <= alu_result;
        end
    end

endmodule

//--- sources.f
rtl/rv_pkg.sv
rtl/rv_exec_if.sv
rtl/inst_decode.sv
rtl/reg_file.sv
rtl/alu_branch_unit.sv
rtl/writeback.sv
rtl/rv_exec_core.sv
dv/rv_exec_assertions.sv
dv/rv_exec_tb.sv
